// ==== sources.f ====
hdl/rom_load_pkg.sv
hdl/rom_byte_router.sv
hdl/prog_write_fifo.sv
hdl/prog_mem_writer.sv
hdl/rom_loader_top.sv
dv/rom_loader_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rom_loader_tb
FILELIST = sources.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/rom_load_patterns.txt ====
# T name starts a test, B addr data is a download byte, E ends a load
# C index data is a config write, M word_addr data mask bank is a memory write in order
T header_starts
B 00 00  B 01 04  B 02 00  B 03 05  B 04 00  B 05 06  B 06 ff  B 07 ff
T decrypt_before_key
B 080040 3c  M 040000 3c3c 2 0
T header_cfg
B 08 a0 C 00 a0  B 09 a1 C 01 a1  B 0a a2 C 02 a2  B 0b a3 C 03 a3
B 0c a4 C 04 a4  B 0d a5 C 05 a5  B 0e a6 C 06 a6  B 0f a7 C 07 a7
B 10 a8 C 08 a8  B 11 a9 C 09 a9  B 12 aa C 0a aa  B 13 ab C 0b ab
B 14 ac C 0c ac  B 15 ad C 0d ad  B 16 ae C 0e ae  B 17 af C 0f af
B 18 b0 C 10 b0  B 19 b1 C 11 b1  B 1a b2 C 12 b2  B 1b b3 C 13 b3
B 1c b4 C 14 b4  B 1d b5 C 15 b5  B 1e b6 C 16 b6  B 1f b7 C 17 b7
B 20 b8 C 18 b8  B 21 b9 C 19 b9  B 22 ba C 1a ba  B 23 bb C 1b bb
B 24 bc C 1c bc  B 25 bd C 1d bd  B 26 be C 1e be  B 27 c0 C 1f c0
B 28 ee  B 3f ee
T cpu_lanes
B 40 11  B 41 22  M 000000 1111 2 0  M 000000 2222 1 0
T decrypt_parity
B 080042 5a  B 080043 5a  B 080044 00  B 080046 ff
M 040001 e1e1 2 0  M 040001 5a5a 1 0  M 040002 d8d8 2 0  M 040003 6a6a 2 0
T region_map
B 100040 77  B 100045 78  B 140040 99  B 140141 9a  B 180040 c3  B 1a0043 c4
M 0c0000 7777 2 0  M 0c0002 7878 1 0  M 010000 9999 2 1
M 010080 9a9a 1 1  M 020000 c3c3 2 2  M 030001 c4c4 1 2
E
T second_load
B 00 00  B 01 08  B 02 00  B 03 09  B 04 00  B 05 0a
B 080040 5a  B 100040 66  B 200042 71  B 240041 92  B 280044 c5
M 040000 5a5a 2 0  M 080000 6666 2 0  M 0c0001 7171 2 0
M 010000 9292 1 1  M 020002 c5c5 2 2

// ==== dv/rom_loader_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom_loader_tb;

    logic                   clk;
    logic                   reset;
    logic                   dl_active;
    logic                   dl_wr;
    rom_load_pkg::dl_addr_t dl_addr;
    rom_load_pkg::byte_t    dl_data;
    logic                   mem_ack;
    logic                   dl_stall;
    logic                   cfg_valid;
    rom_load_pkg::cfg_wr_t  cfg_out;
    logic                   mem_req;
    rom_load_pkg::prog_wr_t mem_wr;

    rom_load_pkg::dl_addr_t stim_addr[$];
    rom_load_pkg::byte_t    stim_data[$];
    bit                     stim_end[$];  // marks the end of a load
    rom_load_pkg::cfg_wr_t  cfg_q[$];
    rom_load_pkg::prog_wr_t mem_q[$];
    string                  cfg_name[$];
    string                  mem_name[$];
    int                     n_records;
    int                     seed = 24;
    bit                     loaded;
    bit                     stall_seen;

    rom_loader_top u_rom_loader_top (.*);

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic expect_fields(input int code, input int want, input string kind);
        if (code != want)
            stop_on_error({"malformed ", kind, " record in patterns file"});
    endtask

    task automatic load_patterns();
        int                       fd;
        int                       code;
        string                    kind;
        string                    test_name;
        logic [8*128-1:0]         line;
        rom_load_pkg::dl_addr_t   ba;
        rom_load_pkg::byte_t      bd;
        logic [4:0]               ci;
        rom_load_pkg::word_addr_t wa;
        logic [15:0]              wd;
        rom_load_pkg::byte_mask_t wm;
        rom_load_pkg::bank_t      wb;
        fd = $fopen("dv/rom_load_patterns.txt", "r");
        if (fd == 0)
            stop_on_error("cannot open dv/rom_load_patterns.txt");
        test_name = "unnamed";
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                code = $fgets(line, fd);  // rest of the comment line
            end else if (kind == "T") begin
                code = $fscanf(fd, "%s", test_name);
                expect_fields(code, 1, kind);
            end else if (kind == "B" || kind == "E") begin
                if (kind == "B") begin
                    code = $fscanf(fd, "%h %h", ba, bd);
                    expect_fields(code, 2, kind);
                end
                stim_addr.push_back(ba);
                stim_data.push_back(bd);
                stim_end.push_back(kind == "E");
            end else if (kind == "C") begin
                code = $fscanf(fd, "%h %h", ci, bd);
                expect_fields(code, 2, kind);
                cfg_q.push_back({ci, bd});
                cfg_name.push_back(test_name);
            end else if (kind == "M") begin
                code = $fscanf(fd, "%h %h %h %h", wa, wd, wm, wb);
                expect_fields(code, 4, kind);
                mem_q.push_back({wa, wd, wm, wb});
                mem_name.push_back(test_name);
            end else begin
                stop_on_error({"unknown record kind in patterns file: ", kind});
            end
            if (kind != "#")
                n_records++;
        end
        $fclose(fd);
    endtask

    task automatic send_byte(input rom_load_pkg::dl_addr_t addr, input rom_load_pkg::byte_t data);
        @(posedge clk);
        while (dl_stall) begin  // downloader held off
            dl_wr <= 1'b0;
            @(posedge clk);
        end
        dl_active <= 1'b1;
        dl_wr     <= 1'b1;
        dl_addr   <= addr;
        dl_data   <= data;
    endtask

    task automatic end_load();
        @(posedge clk);
        dl_wr     <= 1'b0;
        dl_active <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset     = 1'b1;
        dl_active = 1'b0;
        dl_wr     = 1'b0;
        dl_addr   = '0;
        dl_data   = '0;
        load_patterns();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (!dl_stall && !mem_req && !cfg_valid)
            else stop_on_error("outputs are not idle after reset");
        foreach (stim_addr[i]) begin
            if (stim_end[i])
                end_load();
            else
                send_byte(stim_addr[i], stim_data[i]);
        end
        @(posedge clk);
        dl_wr <= 1'b0;
        while (cfg_q.size() != 0 || mem_q.size() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);  // room for a stray extra write
        assert (!mem_req && !mem_ack)
            else stop_on_error("extra memory write after the last expected one");
        if (stall_seen) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_on_error("dl_stall never rose, the FIFO was never under back-pressure");
        end
    end

    // config monitor
    initial begin
        rom_load_pkg::cfg_wr_t exp_cfg;
        string                 name;
        forever begin
            @(posedge clk);
            if (!reset && cfg_valid) begin
                assert (cfg_q.size() > 0)
                    else stop_on_error("configuration write when none was expected");
                exp_cfg = cfg_q.pop_front();
                name    = cfg_name.pop_front();
                assert (cfg_out == exp_cfg)
                    else stop_on_error($sformatf("MISMATCH %s cfg_out: expected %h actual %h",
                                                 name, exp_cfg, cfg_out));
            end
        end
    end

    // memory side, random ack delay and a check per closed handshake
    initial begin
        int unsigned            ack_wait;
        bit                     req_seen;
        rom_load_pkg::prog_wr_t got;
        rom_load_pkg::prog_wr_t exp_wr;
        string                  name;
        mem_ack  = 1'b0;
        req_seen = 1'b0;
        ack_wait = $unsigned($random(seed)) % 8;
        forever begin
            @(posedge clk);
            if (!reset) begin
                if (dl_stall)
                    stall_seen = 1'b1;
                assert (!(mem_req && !req_seen && mem_ack))
                    else stop_on_error("mem_req rose while mem_ack was still high");
                req_seen = mem_req;
                if (mem_req && !mem_ack) begin
                    if (ack_wait == 0) begin
                        mem_ack <= 1'b1;
                        got = mem_wr;
                    end else begin
                        ack_wait--;
                    end
                end else if (!mem_req && mem_ack) begin
                    mem_ack <= 1'b0;
                    ack_wait = $unsigned($random(seed)) % 8;
                    assert (mem_q.size() > 0)
                        else stop_on_error("memory write when none was expected");
                    exp_wr = mem_q.pop_front();
                    name   = mem_name.pop_front();
                    assert (got == exp_wr)
                        else stop_on_error($sformatf("MISMATCH %s mem_wr: expected %h actual %h",
                                                     name, exp_wr, got));
                end
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (n_records * 20) @(posedge clk);
        stop_on_error("timeout, the download and memory writes did not complete");
    end

endmodule

`default_nettype wire

// ==== hdl/rom_loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom_loader_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dl_active,
    input  logic                   dl_wr,
    input  rom_load_pkg::dl_addr_t dl_addr,
    input  rom_load_pkg::byte_t    dl_data,
    input  logic                   mem_ack,
    output logic                   dl_stall,
    output logic                   cfg_valid,
    output rom_load_pkg::cfg_wr_t  cfg_out,
    output logic                   mem_req,
    output rom_load_pkg::prog_wr_t mem_wr
);

    logic                   push;
    rom_load_pkg::prog_wr_t push_data;
    logic                   pop;
    rom_load_pkg::prog_wr_t head;
    logic                   empty;

    rom_byte_router u_rom_byte_router (
        .clk       (clk),
        .reset     (reset),
        .dl_active (dl_active),
        .dl_wr     (dl_wr),
        .dl_addr   (dl_addr),
        .dl_data   (dl_data),
        .cfg_valid (cfg_valid),
        .cfg_out   (cfg_out),
        .push      (push),
        .push_data (push_data)
    );

    prog_write_fifo u_prog_write_fifo (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .push_data   (push_data),
        .pop         (pop),
        .head        (head),
        .empty       (empty),
        .almost_full (dl_stall)  // holds the downloader
    );

    prog_mem_writer u_prog_mem_writer (
        .clk     (clk),
        .reset   (reset),
        .head    (head),
        .empty   (empty),
        .mem_ack (mem_ack),
        .pop     (pop),
        .mem_req (mem_req),
        .mem_wr  (mem_wr)
    );

endmodule

`default_nettype wire

// ==== hdl/prog_mem_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module prog_mem_writer (
    input  logic                   clk,
    input  logic                   reset,
    input  rom_load_pkg::prog_wr_t head,
    input  logic                   empty,
    input  logic                   mem_ack,
    output logic                   pop,
    output logic                   mem_req,
    output rom_load_pkg::prog_wr_t mem_wr
);

    rom_load_pkg::writer_state_t state;
    rom_load_pkg::prog_wr_t      hold;  // request under handshake

    assign pop     = (state == rom_load_pkg::IDLE) && !empty;
    assign mem_req = state == rom_load_pkg::REQ;
    assign mem_wr  = hold;

    always_ff @(posedge clk) begin
        if (pop)
            hold <= head;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rom_load_pkg::IDLE;
        end else begin
            case (state)
                rom_load_pkg::IDLE:
                    if (!empty) state <= rom_load_pkg::REQ;
                rom_load_pkg::REQ:
                    if (mem_ack) state <= rom_load_pkg::WAIT_LOW;  // drop req next
                rom_load_pkg::WAIT_LOW:
                    if (!mem_ack) state <= rom_load_pkg::IDLE;  // handshake closed
                default:
                    state <= rom_load_pkg::IDLE;
            endcase
        end
    end

    a_wr_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req |=> !mem_req || $stable(mem_wr));

    // four-phase rule, memory must have released ack first
    a_req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !mem_ack);

endmodule

`default_nettype wire

// ==== hdl/prog_write_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module prog_write_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  rom_load_pkg::prog_wr_t push_data,
    input  logic                   pop,
    output rom_load_pkg::prog_wr_t head,
    output logic                   empty,
    output logic                   almost_full
);

    rom_load_pkg::prog_wr_t  mem [rom_load_pkg::FIFO_DEPTH];
    rom_load_pkg::fifo_ptr_t wr_ptr;
    rom_load_pkg::fifo_ptr_t rd_ptr;
    rom_load_pkg::fifo_cnt_t count;

    assign head        = mem[rd_ptr];
    assign empty       = count == '0;
    assign almost_full = count >= rom_load_pkg::fifo_cnt_t'(rom_load_pkg::FIFO_STALL_LEVEL);

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == rom_load_pkg::fifo_ptr_t'(rom_load_pkg::FIFO_DEPTH - 1)) ?
                          '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == rom_load_pkg::fifo_ptr_t'(rom_load_pkg::FIFO_DEPTH - 1)) ?
                          '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together
            endcase
        end
    end

    // stall headroom must cover the strobe already in flight
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> count != rom_load_pkg::fifo_cnt_t'(rom_load_pkg::FIFO_DEPTH));

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== hdl/rom_byte_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom_byte_router (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dl_active,
    input  logic                   dl_wr,
    input  rom_load_pkg::dl_addr_t dl_addr,
    input  rom_load_pkg::byte_t    dl_data,
    output logic                   cfg_valid,
    output rom_load_pkg::cfg_wr_t  cfg_out,
    output logic                   push,
    output rom_load_pkg::prog_wr_t push_data
);

    logic [8*rom_load_pkg::START_BYTES-1:0] starts;  // byte 0 ends up lowest
    rom_load_pkg::kb_start_t  snd_start;
    rom_load_pkg::kb_start_t  pcm_start;
    rom_load_pkg::kb_start_t  gfx_start;
    logic                     decrypt_en;
    logic                     parity_sel;

    logic                     strobe;
    logic                     is_start;
    logic                     is_cfg;
    logic                     is_payload;
    rom_load_pkg::dl_addr_t   cfg_rel;

    rom_load_pkg::dl_addr_t   bulk_addr;
    rom_load_pkg::kb_start_t  bulk_kb;
    logic                     region_cpu;
    rom_load_pkg::kb_start_t  region_base;
    rom_load_pkg::word_addr_t region_off;
    rom_load_pkg::bank_t      region_bank;
    rom_load_pkg::dl_addr_t   rel_addr;
    rom_load_pkg::word_addr_t word_addr;
    logic                     do_decrypt;
    rom_load_pkg::byte_t      wr_byte;

    assign snd_start = starts[15:0];
    assign pcm_start = starts[31:16];
    assign gfx_start = starts[47:32];

    assign strobe     = dl_wr && dl_active;
    assign is_start   = dl_addr < rom_load_pkg::START_BYTES;
    assign is_cfg     = dl_addr >= rom_load_pkg::CFG_FIRST && dl_addr <= rom_load_pkg::CFG_LAST;
    assign is_payload = dl_addr >= rom_load_pkg::HEADER_BYTES;
    assign cfg_rel    = dl_addr - rom_load_pkg::CFG_FIRST;

    assign bulk_addr = dl_addr - rom_load_pkg::HEADER_BYTES;
    assign bulk_kb   = {1'b0, bulk_addr[24:10]};

    // highest start wins, anything below the sound start is cpu code
    always_comb begin
        if (bulk_kb >= gfx_start) begin
            region_cpu  = 1'b0;
            region_base = gfx_start;
            region_off  = rom_load_pkg::GFX_OFFSET;
            region_bank = rom_load_pkg::BANK_GFX;
        end else if (bulk_kb >= pcm_start) begin
            region_cpu  = 1'b0;
            region_base = pcm_start;
            region_off  = rom_load_pkg::PCM_OFFSET;
            region_bank = rom_load_pkg::BANK_PCM;
        end else if (bulk_kb >= snd_start) begin
            region_cpu  = 1'b0;
            region_base = snd_start;
            region_off  = rom_load_pkg::SND_OFFSET;
            region_bank = rom_load_pkg::BANK_SND;
        end else begin
            region_cpu  = 1'b1;
            region_base = '0;
            region_off  = rom_load_pkg::CPU_OFFSET;
            region_bank = rom_load_pkg::BANK_CPU;
        end
    end

    assign rel_addr  = bulk_addr - {region_base, 10'd0};
    assign word_addr = rel_addr[23:1] + region_off;  // byte to word address

    // only one byte parity of the upper cpu half is protected
    assign do_decrypt = region_cpu && bulk_addr[rom_load_pkg::DECRYPT_BIT] && decrypt_en
                        && (bulk_addr[0] ^ parity_sel);
    assign wr_byte    = do_decrypt ? rom_load_pkg::cpu_decrypt(dl_data) : dl_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_valid  <= 1'b0;
            push       <= 1'b0;
            starts     <= '0;
            decrypt_en <= 1'b0;
            parity_sel <= 1'b0;
        end else begin
            cfg_valid <= strobe && is_cfg;
            push      <= strobe && is_payload;
            if (!dl_active) begin  // load over, forget the header
                starts     <= '0;
                decrypt_en <= 1'b0;
                parity_sel <= 1'b0;
            end else if (dl_wr) begin
                if (is_start)
                    starts <= {dl_data, starts[8*rom_load_pkg::START_BYTES-1:8]};
                if (dl_addr == rom_load_pkg::CFG_KEY_BYTE)
                    {decrypt_en, parity_sel} <= dl_data[7:6];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            cfg_out.index   <= cfg_rel[4:0];
            cfg_out.data    <= dl_data;
            push_data.addr  <= word_addr;
            push_data.data  <= {2{wr_byte}};
            push_data.mask  <= dl_addr[0] ? 2'b01 : 2'b10;  // even byte is the low lane
            push_data.bank  <= region_bank;
        end
    end

    // header and payload bytes are exclusive
    a_cfg_push_excl: assert property (@(posedge clk) disable iff (reset)
        !(cfg_valid && push));

endmodule

`default_nettype wire

// ==== hdl/rom_load_pkg.sv ====
`default_nettype none

package rom_load_pkg;

    typedef logic [25:0] dl_addr_t;     // byte address from the downloader
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] kb_start_t;    // region start, 1 KB units
    typedef logic [22:0] word_addr_t;
    typedef logic [1:0]  bank_t;
    typedef logic [1:0]  byte_mask_t;   // active low, bit 0 is the low lane

    typedef struct packed {
        word_addr_t  addr;
        logic [15:0] data;  // byte repeated in both lanes
        byte_mask_t  mask;
        bank_t       bank;
    } prog_wr_t;

    typedef struct packed {
        logic [4:0] index;  // header byte minus CFG_FIRST
        byte_t      data;
    } cfg_wr_t;

    typedef enum logic [1:0] {IDLE, REQ, WAIT_LOW} writer_state_t;

    // header layout
    localparam dl_addr_t HEADER_BYTES = 26'd64;
    localparam dl_addr_t START_BYTES  = 26'd6;   // snd, pcm, gfx starts
    localparam dl_addr_t CFG_FIRST    = 26'd8;
    localparam dl_addr_t CFG_LAST     = 26'd39;
    localparam dl_addr_t CFG_KEY_BYTE = 26'd39;  // bit 7 decrypt, bit 6 parity
    localparam int       DECRYPT_BIT  = 19;

    localparam word_addr_t CPU_OFFSET = 23'h000000;
    localparam word_addr_t SND_OFFSET = 23'h0c0000;
    localparam word_addr_t PCM_OFFSET = 23'h010000;
    localparam word_addr_t GFX_OFFSET = 23'h020000;

    localparam bank_t BANK_CPU = 2'd0;
    localparam bank_t BANK_SND = 2'd0;  // sound code shares the cpu bank
    localparam bank_t BANK_PCM = 2'd1;
    localparam bank_t BANK_GFX = 2'd2;

    localparam int FIFO_DEPTH       = 8;
    localparam int FIFO_STALL_LEVEL = 6;  // two slots left for a strobe in flight

    typedef logic [$clog2(FIFO_DEPTH)-1:0]   fifo_ptr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt_t;

    // fixed bit substitution for protected cpu bytes
    function automatic byte_t cpu_decrypt(input byte_t d);
        byte_t r;
        r = 8'h00;
        if (d[0])  r = r ^ 8'h04;
        if (d[1])  r = r ^ 8'h21;
        if (d[2])  r = r ^ 8'h01;
        if (!d[3]) r = r ^ 8'h50;  // inverted sense
        if (d[4])  r = r ^ 8'h40;
        if (d[5])  r = r ^ 8'h06;
        if (d[6])  r = r ^ 8'h08;
        if (!d[7]) r = r ^ 8'h88;  // inverted sense
        return r;
    endfunction

endpackage

`default_nettype wire
